//--- adv_timer_pkg.sv
// Advanced timer subsystem definitions
// Register map, CTRL bit positions and the per-timer config and status structs

package adv_timer_pkg;

   localparam int APB_AW = 8;              // APB address width
   localparam int APB_DW = 32;             // APB data width
   localparam int CNT_W  = 16;             // Counter width used by the struct fields

   // Per-timer register block, one every TMR_STRIDE bytes
   localparam int TMR_STRIDE = 'h20;
   localparam logic [APB_AW-1:0] OFS_CTRL   = 8'h00;
   localparam logic [APB_AW-1:0] OFS_PRESC  = 8'h04;
   localparam logic [APB_AW-1:0] OFS_THRESH = 8'h08;
   localparam logic [APB_AW-1:0] OFS_CMP    = 8'h0C;
   localparam logic [APB_AW-1:0] OFS_COUNT  = 8'h10;   // Read only

   localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h80;  // Global sticky wrap flags

   // CTRL fields
   localparam int CTRL_EN_BIT  = 0;
   localparam int CTRL_SRC_BIT = 1;        // 0 HCLK, 1 low-speed clock
   localparam int CTRL_OS_BIT  = 2;        // One-shot
   localparam int CTRL_CLR_BIT = 3;        // Self-clearing, reads as 0

   // Configuration of one timer core
   typedef struct packed {
      logic             enable;
      logic             src_sel;
      logic             clear;   // One-cycle pulse
      logic [CNT_W-1:0] presc;
      logic [CNT_W-1:0] thresh;
      logic [CNT_W-1:0] cmp;
   } timer_cfg_t;

   // Core state reported back to the register block
   typedef struct packed {
      logic [CNT_W-1:0] count;
      logic             wrap;    // One-cycle pulse on threshold wrap
   } timer_stat_t;

endpackage

//--- lsclk_sync.sv
// Low-speed clock synchronizer
// Brings the slow clock into HCLK and emits one tick per rising edge

`timescale 1ns/1ps

module lsclk_sync (
   input  logic HCLK,
   input  logic arst_n,
   input  logic ls_clk,
   output logic ls_tick
);

   logic ls_meta;   // First sync stage
   logic ls_sync;   // Second sync stage
   logic ls_prev;   // Delayed copy for edge detect

   always_ff @(posedge HCLK or negedge arst_n) begin
      if (!arst_n) begin
         ls_meta <= 1'b0;
         ls_sync <= 1'b0;
         ls_prev <= 1'b0;
         ls_tick <= 1'b0;
      end else begin
         ls_meta <= ls_clk;
         ls_sync <= ls_meta;
         ls_prev <= ls_sync;
         ls_tick <= ls_sync & ~ls_prev;   // Registered so the pulse lands 3 cycles after the edge
      end
   end

endmodule

//--- adv_timer_core.sv
// Single timer core
// Source select, prescaler, wrapping up-counter and compare level output

`timescale 1ns/1ps

module adv_timer_core #(
   parameter int CNT_W = 16
) (
   input  logic                       HCLK,
   input  logic                       arst_n,
   input  logic                       ls_tick,
   input  adv_timer_pkg::timer_cfg_t  cfg,
   output adv_timer_pkg::timer_stat_t stat,
   output logic                       pwm
);

   logic [CNT_W-1:0] presc_cnt;   // Source events since last counter step
   logic [CNT_W-1:0] count_q;     // Main counter
   logic             src_evt;     // One count source event this cycle
   logic             presc_done;
   logic             step;        // Counter advances this cycle
   logic             at_thresh;
   logic             wrap;

   // HCLK source counts every cycle, low-speed source only on the synced tick
   assign src_evt = cfg.src_sel ? ls_tick : 1'b1;

   // Greater-or-equal so a presc lowered on the fly cannot strand the prescaler
   assign presc_done = (presc_cnt >= cfg.presc);

   assign step = cfg.enable & src_evt & presc_done & ~cfg.clear;

   assign at_thresh = (count_q >= cfg.thresh);   // Same idea for thresh

   assign wrap = step & at_thresh;

   // Prescaler
   always_ff @(posedge HCLK or negedge arst_n) begin
      if (!arst_n) begin
         presc_cnt <= '0;
      end else if (cfg.clear) begin
         presc_cnt <= '0;                          // Clear works even when disabled
      end else if (cfg.enable && src_evt) begin
         if (presc_done) begin
            presc_cnt <= '0;
         end else begin
            presc_cnt <= presc_cnt + 1'b1;
         end
      end
   end

   // Counter with threshold wrap
   always_ff @(posedge HCLK or negedge arst_n) begin
      if (!arst_n) begin
         count_q <= '0;
      end else if (cfg.clear) begin
         count_q <= '0;
      end else if (step) begin
         if (at_thresh) begin
            count_q <= '0;                         // Wrap back to zero
         end else begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   // Wrap is combinational so one-shot disable lands on the same edge as the reload
   assign stat = '{count: count_q, wrap: wrap};

   // PWM level decoded from the count register, matches a COUNT read
   assign pwm = (count_q < cfg.cmp);

endmodule

//--- apb_timer_regs.sv
// APB register block for the timer subsystem
// Per-timer config, one-shot disable, sticky wrap status and interrupt

`timescale 1ns/1ps

module apb_timer_regs #(
   parameter int N_TIMERS = 4,
   parameter int CNT_W    = 16
) (
   input  logic                              HCLK,
   input  logic                              arst_n,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [adv_timer_pkg::APB_AW-1:0]  paddr,
   input  logic [adv_timer_pkg::APB_DW-1:0]  pwdata,
   output logic [adv_timer_pkg::APB_DW-1:0]  prdata,
   output logic                              pready,
   output logic                              pslverr,
   output adv_timer_pkg::timer_cfg_t         cfg [N_TIMERS],
   input  adv_timer_pkg::timer_stat_t        stat [N_TIMERS],
   output logic                              irq
);

   import adv_timer_pkg::*;

   timer_cfg_t          cfg_q [N_TIMERS];   // Live config per timer
   logic [N_TIMERS-1:0] one_shot_q;         // Stop on first wrap
   logic [N_TIMERS-1:0] status_q;           // Sticky wrap flags
   logic                irq_q;
   logic                wr_en;
   logic                rd_en;
   logic                wr_status;

   // Absolute address of a register inside timer idx
   function automatic logic [APB_AW-1:0] reg_addr(input int idx, input logic [APB_AW-1:0] ofs);
      return APB_AW'(idx * TMR_STRIDE) + ofs;
   endfunction

   assign wr_en     = psel & penable & pwrite;       // Commit at end of access phase
   assign rd_en     = psel & ~pwrite;
   assign wr_status = wr_en & (paddr == ADDR_STATUS);

   // No wait states, no errors
   assign pready  = 1'b1;
   assign pslverr = 1'b0;

   // Config registers and one-shot handling
   always_ff @(posedge HCLK or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < N_TIMERS; i++) begin
            cfg_q[i] <= '0;
         end
         one_shot_q <= '0;
      end else begin
         for (int i = 0; i < N_TIMERS; i++) begin
            cfg_q[i].clear <= 1'b0;                     // Pulse lasts one cycle
            if (wr_en && paddr == reg_addr(i, OFS_CTRL)) begin
               cfg_q[i].enable  <= pwdata[CTRL_EN_BIT];
               cfg_q[i].src_sel <= pwdata[CTRL_SRC_BIT];
               cfg_q[i].clear   <= pwdata[CTRL_CLR_BIT];
               one_shot_q[i]    <= pwdata[CTRL_OS_BIT];
            end
            if (wr_en && paddr == reg_addr(i, OFS_PRESC)) begin
               cfg_q[i].presc <= pwdata[CNT_W-1:0];
            end
            if (wr_en && paddr == reg_addr(i, OFS_THRESH)) begin
               cfg_q[i].thresh <= pwdata[CNT_W-1:0];
            end
            if (wr_en && paddr == reg_addr(i, OFS_CMP)) begin
               cfg_q[i].cmp <= pwdata[CNT_W-1:0];
            end
            // One-shot stop, same edge as the counter reload to 0
            if (one_shot_q[i] && stat[i].wrap) begin
               cfg_q[i].enable <= 1'b0;
            end
         end
      end
   end

   assign cfg = cfg_q;

   // Sticky status, write 1 to clear, a wrap in the same cycle wins
   always_ff @(posedge HCLK or negedge arst_n) begin
      if (!arst_n) begin
         status_q <= '0;
         irq_q    <= 1'b0;
      end else begin
         for (int i = 0; i < N_TIMERS; i++) begin
            if (stat[i].wrap) begin
               status_q[i] <= 1'b1;
            end else if (wr_status && pwdata[i]) begin
               status_q[i] <= 1'b0;
            end
         end
         irq_q <= |status_q;   // One cycle behind STATUS
      end
   end

   assign irq = irq_q;

   // Read mux, unmapped addresses return 0
   always_comb begin
      prdata = '0;
      if (rd_en) begin
         for (int i = 0; i < N_TIMERS; i++) begin
            if (paddr == reg_addr(i, OFS_CTRL)) begin
               prdata[CTRL_EN_BIT]  = cfg_q[i].enable;
               prdata[CTRL_SRC_BIT] = cfg_q[i].src_sel;
               prdata[CTRL_OS_BIT]  = one_shot_q[i];   // Clear bit stays 0
            end
            if (paddr == reg_addr(i, OFS_PRESC))  prdata[CNT_W-1:0] = cfg_q[i].presc;
            if (paddr == reg_addr(i, OFS_THRESH)) prdata[CNT_W-1:0] = cfg_q[i].thresh;
            if (paddr == reg_addr(i, OFS_CMP))    prdata[CNT_W-1:0] = cfg_q[i].cmp;
            if (paddr == reg_addr(i, OFS_COUNT))  prdata[CNT_W-1:0] = stat[i].count;
         end
         if (paddr == ADDR_STATUS) begin
            prdata[N_TIMERS-1:0] = status_q;
         end
      end
   end

endmodule

//--- apb_adv_timer_ss.sv
// APB advanced timer subsystem top
// Register block, low-speed clock synchronizer and N_TIMERS timer cores

`timescale 1ns/1ps

module apb_adv_timer_ss #(
   parameter int N_TIMERS = 4,
   parameter int CNT_W    = 16
) (
   input  logic                             HCLK,
   input  logic                             arst_n,
   input  logic                             ls_clk,     // Slow clock, sampled into HCLK
   input  logic                             psel,
   input  logic                             penable,
   input  logic                             pwrite,
   input  logic [adv_timer_pkg::APB_AW-1:0] paddr,
   input  logic [adv_timer_pkg::APB_DW-1:0] pwdata,
   output logic [adv_timer_pkg::APB_DW-1:0] prdata,
   output logic                             pready,
   output logic                             pslverr,
   output logic [N_TIMERS-1:0]              pwm,
   output logic                             irq
);

   import adv_timer_pkg::*;

   timer_cfg_t  cfg  [N_TIMERS];   // Register block to cores
   timer_stat_t stat [N_TIMERS];   // Cores back to register block
   logic        ls_tick;           // One pulse per low-speed rising edge

   lsclk_sync i_lsclk_sync (
      .HCLK    (HCLK),
      .arst_n  (arst_n),
      .ls_clk  (ls_clk),
      .ls_tick (ls_tick)
   );

   apb_timer_regs #(
      .N_TIMERS (N_TIMERS),
      .CNT_W    (CNT_W)
   ) i_apb_timer_regs (
      .HCLK    (HCLK),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .cfg     (cfg),
      .stat    (stat),
      .irq     (irq)
   );

   for (genvar i = 0; i < N_TIMERS; i++) begin : g_core
      adv_timer_core #(
         .CNT_W (CNT_W)
      ) i_adv_timer_core (
         .HCLK    (HCLK),
         .arst_n  (arst_n),
         .ls_tick (ls_tick),
         .cfg     (cfg[i]),
         .stat    (stat[i]),
         .pwm     (pwm[i])
      );
   end

endmodule

//--- apb_adv_timer_ss_assert.sv
// Timer subsystem checker, bound into the subsystem top
// APB handshake rules, interrupt origin and counter width agreement

`timescale 1ns/1ps

module apb_adv_timer_ss_assert #(
   parameter int N_TIMERS   = 4,
   parameter int CORE_CNT_W = 16
) (
   input logic                       HCLK,
   input logic                       arst_n,
   input logic                       psel,
   input logic                       penable,
   input logic                       pready,
   input logic                       pslverr,
   input logic                       irq,
   input adv_timer_pkg::timer_stat_t stat [N_TIMERS]   // Core outputs towards the register block
);

   import adv_timer_pkg::*;

   logic any_wrap;   // Some core wraps this cycle

   always_comb begin
      any_wrap = 1'b0;
      for (int i = 0; i < N_TIMERS; i++) begin
         any_wrap = any_wrap | stat[i].wrap;
      end
   end

   // Slave never stalls and never errors
   a_pready: assert property (@(posedge HCLK) disable iff (!arst_n) pready && !pslverr)
      else $error("pready low or pslverr high");

   // Access phase only right after a setup phase
   a_penable: assert property (@(posedge HCLK) disable iff (!arst_n)
      penable |-> psel && $past(psel && !penable))
      else $error("penable without a preceding setup cycle");

   // STATUS follows a wrap by one cycle, irq by one more
   a_irq_src: assert property (@(posedge HCLK) disable iff (!arst_n)
      $rose(irq) |-> $past(any_wrap, 2))
      else $error("irq rose without a timer wrap two cycles before");

   a_cnt_w: assert property (@(posedge HCLK) CNT_W == CORE_CNT_W)   // Struct width vs parameter
      else $error("package counter width differs from the CNT_W parameter");

endmodule

//--- apb_adv_timer_ss_tb.sv
// Testbench for the APB advanced timer subsystem
// Replays the vector file through an APB driver and checks prdata, pwm and irq

`timescale 1ns/1ps

module apb_adv_timer_ss_tb;

   import adv_timer_pkg::*;

   localparam int    N_TIMERS = 4;
   localparam int    RST_CYC  = 16;
   localparam int    MARGIN   = 200;                          // Extra cycles on the timeout
   localparam string VEC_FILE = "apb_adv_timer_ss_vectors.txt";

   logic                HCLK;
   logic                arst_n;
   logic                ls_clk;
   logic                psel;
   logic                penable;
   logic                pwrite;
   logic [APB_AW-1:0]   paddr;
   logic [APB_DW-1:0]   pwdata;
   logic [APB_DW-1:0]   prdata;
   logic                pready;
   logic                pslverr;
   logic [N_TIMERS-1:0] pwm;
   logic                irq;

   int cyc_cnt   = 0;
   int cyc_limit = 0;   // Zero until the vector file has been scanned

   apb_adv_timer_ss #(
      .N_TIMERS (N_TIMERS),
      .CNT_W    (CNT_W)
   ) i_apb_adv_timer_ss (
      .HCLK    (HCLK),
      .arst_n  (arst_n),
      .ls_clk  (ls_clk),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .pwm     (pwm),
      .irq     (irq)
   );

   bind apb_adv_timer_ss apb_adv_timer_ss_assert #(
      .N_TIMERS   (N_TIMERS),
      .CORE_CNT_W (CNT_W)
   ) i_apb_adv_timer_ss_assert (
      .HCLK    (HCLK),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pready  (pready),
      .pslverr (pslverr),
      .irq     (irq),
      .stat    (stat)
   );

   initial HCLK = 1'b0;
   always #4 HCLK = ~HCLK;   // 8 ns period

   // Run length guard
   always @(posedge HCLK) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_limit != 0 && cyc_cnt >= cyc_limit) begin
         $display("Run did not finish the vector file within %0d cycles", cyc_limit);
         $display("Test FAILED");
         $fatal(1, "Timeout");
      end
   end

   task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
      if (act_val !== exp_val) begin
         $display("ERROR %0s: expected %08h, actual %08h", name, exp_val, act_val);
         $display("Test FAILED");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // One setup cycle, one access cycle
   task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                           input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata);
      @(posedge HCLK);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge HCLK);
      penable <= 1'b1;
      @(negedge HCLK);
      rdata = prdata;          // Mid access cycle
      @(posedge HCLK);         // Write commits here
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge HCLK);
   endtask

   // Each period is 8 HCLK cycles, high for the first 4
   task automatic ls_periods(input int n);
      repeat (n) begin
         @(posedge HCLK);
         ls_clk <= 1'b1;
         repeat (4) @(posedge HCLK);
         ls_clk <= 1'b0;
         repeat (3) @(posedge HCLK);
      end
   endtask

   // Dry run only sums the expected length, otherwise drives and checks
   task automatic run_vectors(input bit dry_run, output int est_cycles);
      int               fd;
      int               code;
      logic [7:0]       op;
      logic [31:0]      arg_a;
      logic [31:0]      arg_b;
      logic [8*24-1:0]  name;
      logic [8*128-1:0] rest;
      logic [31:0]      rdata;
      est_cycles = 0;
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the vector file %0s", VEC_FILE);
         $display("Test FAILED");
         $fatal(1, "No stimulus");
      end
      while ($fscanf(fd, "%s", op) == 1) begin
         if (op == "#") begin
            code = $fgets(rest, fd);               // Comment line
         end else begin
            code = $fscanf(fd, "%h %h %s", arg_a, arg_b, name);
            if (code != 3) begin
               $display("Vector line with opcode %c has missing fields", op);
               $display("Test FAILED");
               $fatal(1, "Bad vector file");
            end
            case (op)
               "W", "R": est_cycles += 4;
               "I":      est_cycles += arg_a;
               "L":      est_cycles += 8 * arg_a;
               default:  est_cycles += 1;
            endcase
            if (!dry_run) begin
               case (op)
                  "W": apb_xfer(1'b1, arg_a[APB_AW-1:0], arg_b, rdata);
                  "R": begin
                     apb_xfer(1'b0, arg_a[APB_AW-1:0], '0, rdata);
                     check_value(name, arg_b, rdata);
                  end
                  "I": idle_cycles(arg_a);
                  "L": ls_periods(arg_a);
                  "P": begin
                     @(negedge HCLK);
                     check_value(name, arg_a, 32'(pwm));
                  end
                  "Q": begin
                     @(negedge HCLK);
                     check_value(name, arg_a, 32'(irq));
                  end
                  default: begin
                     $display("Unknown opcode %c in the vector file", op);
                     $display("Test FAILED");
                     $fatal(1, "Bad vector file");
                  end
               endcase
            end
         end
      end
      $fclose(fd);
   endtask

   initial begin
      int est;
      arst_n  <= 1'b0;
      ls_clk  <= 1'b0;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= '0;
      pwdata  <= '0;
      run_vectors(1'b1, est);
      cyc_limit = est + RST_CYC + MARGIN;
      repeat (RST_CYC) @(posedge HCLK);
      arst_n <= 1'b1;
      run_vectors(1'b0, est);
      $display("Test OK");
      $finish;
   end

endmodule

//--- apb_adv_timer_ss_vectors.txt
# op arg_a arg_b name: W addr data, R addr expected, I idle cycles, L low-speed periods,
# P pwm mask, Q irq level; all numbers hex, name - on lines without a check
# Reset values and register readback, clear bit reads 0
R 00 0 rst_ctrl0
R 14 0 rst_unmapped
R 80 0 rst_status
P 0 0 rst_pwm
Q 0 0 rst_irq
W 24 dead1234 -
W 28 abcd -
W 2c ff -
W 20 e -
R 20 6 rd_ctrl1
R 24 1234 rd_presc1
R 28 abcd rd_thresh1
R 2c ff rd_cmp1
# Timer 0 on HCLK, presc 3, thresh f
W 04 3 -
W 08 f -
W 00 1 -
I a 0 -
R 10 3 cnt_three_steps
R 10 3 cnt_stable
W 00 9 -
R 10 0 cnt_cleared
# Wrap, status and irq
I 46 0 -
R 80 1 status_wrap0
Q 1 0 irq_set
W 00 0 -
W 80 1 -
I 2 0 -
Q 0 0 irq_cleared
R 80 0 status_cleared
# Compare level, timer 0 stopped at 3, timer 1 at 0 with cmp ff
R 10 3 cnt_frozen
W 0c 4 -
P 3 0 pwm_cmp4
W 0c 3 -
P 2 0 pwm_cmp3
# Timer 2 on the low-speed clock
W 48 ff -
W 40 3 -
L 5 0 -
I 4 0 -
R 50 5 ls_cnt5
I 14 0 -
R 50 5 ls_cnt_hold
W 40 0 -
# Timer 3 one-shot, presc 1, thresh 3
W 64 1 -
W 68 3 -
W 60 5 -
I 14 0 -
R 60 4 oneshot_ctrl
R 70 0 oneshot_cnt
R 80 8 oneshot_status
Q 1 0 oneshot_irq

//--- files.f
adv_timer_pkg.sv
lsclk_sync.sv
adv_timer_core.sv
apb_timer_regs.sv
apb_adv_timer_ss.sv
apb_adv_timer_ss_assert.sv
apb_adv_timer_ss_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the timer subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f files.f --top-module apb_adv_timer_ss_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vapb_adv_timer_ss_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^Test OK$" sim.log; then
   exit 0
fi
echo "Pass line not found in sim.log"
exit 1
